//--- hw/lsu_config.svh
`ifndef LSU_CONFIG_SVH
`define LSU_CONFIG_SVH

// data memory window

// first byte address of the window
`define LSU_MEM_BASE 32'h8000_0000

// depth in 64-bit words, 256 gives 2 KiB
`define LSU_MEM_WORDS 256

`endif

//--- hw/lsu_pkg.sv
package lsu_pkg;

  // load functions, funct3 encoding of the rv32 loads
  // S suffix sign-extends, U suffix zero-extends
  typedef enum logic [2:0] {
    LD_BS = 3'b000,
    LD_HS = 3'b001,
    LD_W  = 3'b010,
    LD_BU = 3'b100,
    LD_HU = 3'b101
  } ld_func_t;

  // store functions, funct3 encoding of the rv32 stores
  typedef enum logic [2:0] {
    ST_B = 3'b000,
    ST_H = 3'b001,
    ST_W = 3'b010
  } st_func_t;

  // memory response code
  // only okay and slave error are produced
  typedef enum logic [1:0] {
    RESP_OKAY   = 2'b00,
    RESP_SLVERR = 2'b10
  } mem_resp_t;

endpackage

//--- hw/load_unit.sv
`timescale 1ns/1ns

module load_unit
  import lsu_pkg::*;
(
  input  logic        clk,
  input  logic        rstn,
  // read request from the core
  input  logic        rreq_valid,
  output logic        rreq_ready,
  input  logic [31:0] raddr,
  input  ld_func_t    rfunc,
  // read response to the core
  output logic        rres_valid,
  input  logic        rres_ready,
  output logic [31:0] rdata,
  output logic        rerr,
  // read channel to the memory
  output logic        arvalid,
  output logic [31:0] araddr,
  input  logic        arready,
  input  logic        rvalid,
  input  logic [31:0] mem_rdata,
  input  mem_resp_t   rresp,
  output logic        rready
);

  // lane offset and function of the load in flight
  logic [1:0]  lane_q;
  ld_func_t    func_q;
  logic        ar_hs;
  // returned word moved down to byte lane 0
  logic [31:0] shifted;

  assign ar_hs = rreq_valid & rreq_ready;

  // request side passes straight through
  assign arvalid    = rreq_valid;
  assign rreq_ready = arready;
  // word-aligned read, lane picked on return
  assign araddr     = {raddr[31:2], 2'b00};

  // capture on the request handshake
  // the memory holds off the next request until the response is taken
  always_ff @(posedge clk) begin
    if (!rstn) begin
      lane_q <= 2'b00;
      func_q <= LD_W;
    end else if (ar_hs) begin
      lane_q <= raddr[1:0];
      func_q <= rfunc;
    end
  end

  // right-align, upper lanes fill with zero
  assign shifted = mem_rdata >> {lane_q, 3'b000};

  // sign or zero extension
  always_comb begin
    case (func_q)
      LD_BS:   rdata = {{24{shifted[7]}}, shifted[7:0]};
      LD_BU:   rdata = {24'h00_0000, shifted[7:0]};
      LD_HS:   rdata = {{16{shifted[15]}}, shifted[15:0]};
      LD_HU:   rdata = {16'h0000, shifted[15:0]};
      // LD_W and anything unknown pass the word
      default: rdata = shifted;
    endcase
  end

  // response side passes straight through
  assign rres_valid = rvalid;
  assign rready     = rres_ready;
  // error flag beside the data
  assign rerr       = (rresp == RESP_SLVERR);

endmodule

//--- hw/store_unit.sv
`timescale 1ns/1ns

module store_unit
  import lsu_pkg::*;
(
  input  logic        clk,
  input  logic        rstn,
  // write request from the core
  input  logic        wreq_valid,
  output logic        wreq_ready,
  input  logic [31:0] waddr,
  input  st_func_t    wfunc,
  input  logic [31:0] wdata,
  // write response to the core
  output logic        wres_valid,
  input  logic        wres_ready,
  output logic        werr,
  // write address phase
  output logic        awvalid,
  output logic [31:0] awaddr,
  input  logic        awready,
  // write data phase
  output logic        wvalid,
  output logic [63:0] mem_wdata,
  output logic [7:0]  wstrb,
  input  logic        wready,
  // write response phase
  input  logic        bvalid,
  input  mem_resp_t   bresp,
  output logic        bready
);

  // phase already handed to the memory, waiting for the response
  logic        aw_sent;
  logic        w_sent;
  // phase still to be handed over for the current request
  logic        aw_owed;
  logic        w_owed;
  logic        aw_hs;
  logic        w_hs;
  logic        b_hs;
  // strobe before the lane shift
  logic [7:0]  base_strb;

  assign aw_hs = awvalid & awready;
  assign w_hs  = wvalid & wready;
  assign b_hs  = bvalid & bready;

  // one, two or four bytes
  always_comb begin
    case (wfunc)
      ST_B:    base_strb = 8'b0000_0001;
      ST_H:    base_strb = 8'b0000_0011;
      default: base_strb = 8'b0000_1111;
    endcase
  end

  // place data and strobe at byte offset within the beat
  // anything pushed past byte 7 falls off
  assign mem_wdata = {32'h0000_0000, wdata} << {waddr[2:0], 3'b000};
  assign wstrb     = base_strb << waddr[2:0];
  // beat-aligned address
  assign awaddr    = {waddr[31:3], 3'b000};

  assign aw_owed = ~aw_sent;
  assign w_owed  = ~w_sent;

  // each phase only offered while still owed
  assign awvalid = wreq_valid & aw_owed;
  assign wvalid  = wreq_valid & w_owed;

  // accept once the last owed phase goes through
  // nothing owed means a response is pending, so hold off
  assign wreq_ready = (aw_owed | w_owed)
                    & (awready | ~aw_owed)
                    & (wready | ~w_owed);

  // phase tracking
  // both phases owed again after the response handshake
  always_ff @(posedge clk) begin
    if (!rstn) begin
      aw_sent <= 1'b0;
      w_sent  <= 1'b0;
    end else if (b_hs) begin
      aw_sent <= 1'b0;
      w_sent  <= 1'b0;
    end else begin
      if (aw_hs) begin
        aw_sent <= 1'b1;
      end
      if (w_hs) begin
        w_sent <= 1'b1;
      end
    end
  end

  // response passes straight through
  assign wres_valid = bvalid;
  assign bready     = wres_ready;
  assign werr       = (bresp == RESP_SLVERR);

endmodule

//--- hw/data_ram.sv
`timescale 1ns/1ns
`include "lsu_config.svh"

module data_ram
  import lsu_pkg::*;
(
  input  logic        clk,
  input  logic        rstn,
  // read channel
  input  logic        arvalid,
  input  logic [31:0] araddr,
  output logic        arready,
  output logic        rvalid,
  output logic [31:0] rdata,
  output mem_resp_t   rresp,
  input  logic        rready,
  // write channel
  input  logic        awvalid,
  input  logic [31:0] awaddr,
  output logic        awready,
  input  logic        wvalid,
  input  logic [63:0] wdata,
  input  logic [7:0]  wstrb,
  output logic        wready,
  output logic        bvalid,
  output mem_resp_t   bresp,
  input  logic        bready
);

  localparam int unsigned WORDS = `LSU_MEM_WORDS;
  localparam int unsigned IDX_W = $clog2(WORDS);
  localparam logic [31:0] BASE  = `LSU_MEM_BASE;
  // window size in bytes
  localparam logic [31:0] SPAN  = 32'(WORDS * 8);

  // 64-bit word array, contents not reset
  logic [63:0] mem [WORDS];

  // read side
  logic             ar_hs;
  logic             r_hs;
  logic [31:0]      r_off;
  logic             r_hit;
  logic [IDX_W-1:0] r_idx;

  // write side
  logic             aw_hs;
  logic             w_hs;
  logic             b_hs;
  logic             aw_cap;
  logic             w_cap;
  logic [31:0]      awaddr_q;
  logic [63:0]      wdata_q;
  logic [7:0]       wstrb_q;
  logic [31:0]      wr_addr;
  logic [63:0]      wr_data;
  logic [7:0]       wr_strb;
  logic             do_write;
  logic [31:0]      w_off;
  logic             w_hit;
  logic [IDX_W-1:0] w_idx;
  logic             aw_cap_n;
  logic             w_cap_n;
  logic             bvalid_n;

  assign ar_hs = arvalid & arready;
  assign r_hs  = rvalid & rready;

  // offset from base, below base wraps high and misses
  assign r_off = araddr - BASE;
  assign r_hit = (r_off < SPAN);
  assign r_idx = r_off[IDX_W+2:3];

  // one read outstanding at a time
  assign arready = ~rvalid;

  always_ff @(posedge clk) begin
    if (!rstn) begin
      rvalid <= 1'b0;
    end else if (ar_hs) begin
      rvalid <= 1'b1;
    end else if (r_hs) begin
      rvalid <= 1'b0;
    end
  end

  // read at the request edge, held until taken
  // half of the word chosen by address bit 2
  always_ff @(posedge clk) begin
    if (ar_hs) begin
      if (r_hit) begin
        rdata <= araddr[2] ? mem[r_idx][63:32] : mem[r_idx][31:0];
        rresp <= RESP_OKAY;
      end else begin
        rdata <= 32'h0000_0000;
        rresp <= RESP_SLVERR;
      end
    end
  end

  assign aw_hs = awvalid & awready;
  assign w_hs  = wvalid & wready;
  assign b_hs  = bvalid & bready;

  // a phase arriving now bypasses its capture register
  assign wr_addr = aw_cap ? awaddr_q : awaddr;
  assign wr_data = w_cap ? wdata_q : wdata;
  assign wr_strb = w_cap ? wstrb_q : wstrb;

  // both phases in hand on this edge
  assign do_write = (aw_cap | aw_hs) & (w_cap | w_hs);

  assign w_off = wr_addr - BASE;
  assign w_hit = (w_off < SPAN);
  assign w_idx = w_off[IDX_W+2:3];

  // next state of the write control
  always_comb begin
    aw_cap_n = aw_cap;
    w_cap_n  = w_cap;
    bvalid_n = bvalid;
    if (do_write) begin
      aw_cap_n = 1'b0;
      w_cap_n  = 1'b0;
      bvalid_n = 1'b1;
    end else begin
      if (aw_hs) begin
        aw_cap_n = 1'b1;
      end
      if (w_hs) begin
        w_cap_n = 1'b1;
      end
      if (b_hs) begin
        bvalid_n = 1'b0;
      end
    end
  end

  // readies registered so they stay low through reset
  always_ff @(posedge clk) begin
    if (!rstn) begin
      aw_cap  <= 1'b0;
      w_cap   <= 1'b0;
      bvalid  <= 1'b0;
      awready <= 1'b0;
      wready  <= 1'b0;
    end else begin
      aw_cap  <= aw_cap_n;
      w_cap   <= w_cap_n;
      bvalid  <= bvalid_n;
      awready <= ~aw_cap_n & ~bvalid_n;
      wready  <= ~w_cap_n & ~bvalid_n;
    end
  end

  // phase payloads and the response code
  always_ff @(posedge clk) begin
    if (aw_hs) begin
      awaddr_q <= awaddr;
    end
    if (w_hs) begin
      wdata_q <= wdata;
      wstrb_q <= wstrb;
    end
    if (do_write) begin
      bresp <= w_hit ? RESP_OKAY : RESP_SLVERR;
    end
  end

  // strobed byte write, out of range leaves memory alone
  always_ff @(posedge clk) begin
    if (do_write && w_hit) begin
      for (int i = 0; i < 8; i++) begin
        if (wr_strb[i]) begin
          mem[w_idx][8*i +: 8] <= wr_data[8*i +: 8];
        end
      end
    end
  end

endmodule

//--- hw/lsu_top.sv
`timescale 1ns/1ns

module lsu_top
  import lsu_pkg::*;
(
  input  logic        clk,
  input  logic        rstn,
  // load request
  input  logic        rreq_valid,
  output logic        rreq_ready,
  input  logic [31:0] raddr,
  input  ld_func_t    rfunc,
  // load response
  output logic        rres_valid,
  input  logic        rres_ready,
  output logic [31:0] rdata,
  output logic        rerr,
  // store request
  input  logic        wreq_valid,
  output logic        wreq_ready,
  input  logic [31:0] waddr,
  input  st_func_t    wfunc,
  input  logic [31:0] wdata,
  // store response
  output logic        wres_valid,
  input  logic        wres_ready,
  output logic        werr
);

  // read channel
  logic        arvalid;
  logic [31:0] araddr;
  logic        arready;
  logic        rvalid;
  logic [31:0] mem_rdata;
  mem_resp_t   rresp;
  logic        rready;

  // write channel
  logic        awvalid;
  logic [31:0] awaddr;
  logic        awready;
  logic        wvalid;
  logic [63:0] mem_wdata;
  logic [7:0]  wstrb;
  logic        wready;
  logic        bvalid;
  mem_resp_t   bresp;
  logic        bready;

  // load path
  load_unit u_load (
    .clk        (clk),
    .rstn       (rstn),
    .rreq_valid (rreq_valid),
    .rreq_ready (rreq_ready),
    .raddr      (raddr),
    .rfunc      (rfunc),
    .rres_valid (rres_valid),
    .rres_ready (rres_ready),
    .rdata      (rdata),
    .rerr       (rerr),
    .arvalid    (arvalid),
    .araddr     (araddr),
    .arready    (arready),
    .rvalid     (rvalid),
    .mem_rdata  (mem_rdata),
    .rresp      (rresp),
    .rready     (rready)
  );

  // store path
  store_unit u_store (
    .clk        (clk),
    .rstn       (rstn),
    .wreq_valid (wreq_valid),
    .wreq_ready (wreq_ready),
    .waddr      (waddr),
    .wfunc      (wfunc),
    .wdata      (wdata),
    .wres_valid (wres_valid),
    .wres_ready (wres_ready),
    .werr       (werr),
    .awvalid    (awvalid),
    .awaddr     (awaddr),
    .awready    (awready),
    .wvalid     (wvalid),
    .mem_wdata  (mem_wdata),
    .wstrb      (wstrb),
    .wready     (wready),
    .bvalid     (bvalid),
    .bresp      (bresp),
    .bready     (bready)
  );

  // shared data memory
  data_ram u_ram (
    .clk     (clk),
    .rstn    (rstn),
    .arvalid (arvalid),
    .araddr  (araddr),
    .arready (arready),
    .rvalid  (rvalid),
    .rdata   (mem_rdata),
    .rresp   (rresp),
    .rready  (rready),
    .awvalid (awvalid),
    .awaddr  (awaddr),
    .awready (awready),
    .wvalid  (wvalid),
    .wdata   (mem_wdata),
    .wstrb   (wstrb),
    .wready  (wready),
    .bvalid  (bvalid),
    .bresp   (bresp),
    .bready  (bready)
  );

endmodule

//--- verif/lsu_tb.sv
`timescale 1ns/1ns
`include "lsu_config.svh"

module lsu_tb
  import lsu_pkg::*;
();

  localparam logic [31:0] BASE = `LSU_MEM_BASE;
  localparam logic [31:0] SPAN = 32'(`LSU_MEM_WORDS * 8);
  // longest wait for one handshake or response
  localparam int RESP_WAIT = 50;
  // about 120 transactions at up to 20 cycles each plus margin
  localparam int TIMEOUT_CYCLES = 4000;

  logic        clk;
  logic        rstn;
  logic        rreq_valid;
  logic        rreq_ready;
  logic [31:0] raddr;
  ld_func_t    rfunc;
  logic        rres_valid;
  logic        rres_ready;
  logic [31:0] rdata;
  logic        rerr;
  logic        wreq_valid;
  logic        wreq_ready;
  logic [31:0] waddr;
  st_func_t    wfunc;
  logic [31:0] wdata;
  logic        wres_valid;
  logic        wres_ready;
  logic        werr;

  // expected memory bytes by address
  // only written bytes present
  logic [7:0]  sb [logic [31:0]];
  integer      seed = 32'hff25_c91b;
  int          cycle_cnt = 0;

  lsu_top UUT (.*);

  // 20 ns clock
  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  task automatic abort_run(input string line);
    $display("%s", line);
    $display("ERRORS FOUND");
    $fatal(1, "simulation stopped at the first error");
  endtask

  // whole-run limit
  always @(posedge clk) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt >= TIMEOUT_CYCLES) begin
      abort_run($sformatf("run timed out after %0d cycles", cycle_cnt));
    end
  end

  task automatic check_data(input ld_func_t func, input logic [31:0] got,
                            input logic [31:0] exp, input logic [31:0] addr);
    if (got !== exp) begin
      abort_run($sformatf("Mismatch at %0t: %s from %h returned %h, expected %h",
                          $time, func.name(), addr, got, exp));
    end
  endtask

  task automatic check_err(input logic got, input logic exp, input string what);
    if (got !== exp) begin
      abort_run($sformatf("Mismatch at %0t: %s error flag %b, expected %b",
                          $time, what, got, exp));
    end
  endtask

  task automatic check_flag(input logic got, input logic exp, input string what);
    if (got !== exp) begin
      abort_run($sformatf("Mismatch at %0t: %s is %b, expected %b", $time, what, got, exp));
    end
  endtask

  task automatic check_cycles(input int got, input int exp, input string what);
    if (got != exp) begin
      abort_run($sformatf("Mismatch at %0t: %s took %0d cycles, expected %0d",
                          $time, what, got, exp));
    end
  endtask

  // byte lanes of a store land at their own addresses
  function automatic void model_store(input logic [31:0] addr, input st_func_t func,
                                      input logic [31:0] data);
    int n;
    n = (func == ST_B) ? 1 : (func == ST_H) ? 2 : 4;
    for (int i = 0; i < n; i++) begin
      sb[addr + 32'(i)] = data[8*i +: 8];
    end
  endfunction

  // expected load result built from the scoreboard bytes
  function automatic logic [31:0] expect_load(input logic [31:0] addr, input ld_func_t func);
    logic [7:0]  b;
    logic [15:0] h;
    b = sb[addr];
    case (func)
      LD_BS: return {{24{b[7]}}, b};
      LD_BU: return {24'h00_0000, b};
      LD_HS: begin
        h = {sb[addr + 32'd1], b};
        return {{16{h[15]}}, h};
      end
      LD_HU: begin
        h = {sb[addr + 32'd1], b};
        return {16'h0000, h};
      end
      default: return {sb[addr + 32'd3], sb[addr + 32'd2], sb[addr + 32'd1], b};
    endcase
  endfunction

  // lat counts cycles from the handshake edge to wres_valid
  task automatic do_store(input logic [31:0] addr, input st_func_t func,
                          input logic [31:0] data, output logic err, output int lat);
    int waits;
    @(posedge clk);
    wreq_valid <= 1'b1;
    waddr      <= addr;
    wfunc      <= func;
    wdata      <= data;
    waits = 0;
    @(negedge clk);
    while (!wreq_ready) begin
      waits++;
      if (waits > RESP_WAIT) begin
        abort_run($sformatf("store request to %h was never accepted", addr));
      end
      @(negedge clk);
    end
    // handshake on this edge
    @(posedge clk);
    wreq_valid <= 1'b0;
    lat = 1;
    @(negedge clk);
    while (!wres_valid) begin
      lat++;
      if (lat > RESP_WAIT) begin
        abort_run($sformatf("no store response for %h within %0d cycles", addr, RESP_WAIT));
      end
      @(negedge clk);
    end
    err = werr;
  endtask

  // one load and its response
  task automatic do_load(input logic [31:0] addr, input ld_func_t func,
                         output logic [31:0] data, output logic err, output int lat);
    int waits;
    @(posedge clk);
    rreq_valid <= 1'b1;
    raddr      <= addr;
    rfunc      <= func;
    waits = 0;
    @(negedge clk);
    while (!rreq_ready) begin
      waits++;
      if (waits > RESP_WAIT) begin
        abort_run($sformatf("load request to %h was never accepted", addr));
      end
      @(negedge clk);
    end
    @(posedge clk);
    rreq_valid <= 1'b0;
    lat = 1;
    @(negedge clk);
    while (!rres_valid) begin
      lat++;
      if (lat > RESP_WAIT) begin
        abort_run($sformatf("no load response for %h within %0d cycles", addr, RESP_WAIT));
      end
      @(negedge clk);
    end
    data = rdata;
    err  = rerr;
  endtask

  // in-range store with the response ready held high
  task automatic store_and_track(input logic [31:0] addr, input st_func_t func,
                                 input logic [31:0] data);
    logic err;
    int   lat;
    do_store(addr, func, data, err, lat);
    check_err(err, 1'b0, "store");
    check_cycles(lat, 1, "store response");
    // next store blocked while the response is pending
    check_flag(wreq_ready, 1'b0, "wreq_ready with a store response pending");
    model_store(addr, func, data);
  endtask

  task automatic load_and_compare(input logic [31:0] addr, input ld_func_t func);
    logic [31:0] got;
    logic        err;
    int          lat;
    do_load(addr, func, got, err, lat);
    check_err(err, 1'b0, "load");
    check_cycles(lat, 1, "load response");
    check_data(func, got, expect_load(addr, func), addr);
  endtask

  // both halves of several 64-bit words
  // first and last word of the window too
  task automatic word_round_trip();
    logic [31:0] offs [8];
    offs = '{32'h000, 32'h004, 32'h008, 32'h00c, 32'h100, 32'h104, 32'h7f8, 32'h7fc};
    foreach (offs[i]) begin
      store_and_track(BASE + offs[i], ST_W, $random(seed));
    end
    foreach (offs[i]) begin
      load_and_compare(BASE + offs[i], LD_W);
    end
  endtask

  task automatic byte_half_merge();
    logic [31:0] w;
    for (int k = 0; k < 2; k++) begin
      w = BASE + 32'h020 + 32'(4 * k);
      store_and_track(w, ST_W, $random(seed));
      for (int off = 0; off < 4; off++) begin
        store_and_track(w + 32'(off), ST_B, $random(seed));
        load_and_compare(w, LD_W);
      end
      store_and_track(w, ST_H, $random(seed));
      load_and_compare(w, LD_W);
      store_and_track(w + 32'd2, ST_H, $random(seed));
      load_and_compare(w, LD_W);
    end
  endtask

  // patterns with and without the sign bits set
  task automatic load_extension();
    logic [31:0] pats [3];
    logic [31:0] w;
    pats = '{32'h8f7e_c301, 32'h7f80_01ff, 32'h0000_0000};
    pats[2] = $random(seed) | 32'h8080_8080;
    for (int k = 0; k < 3; k++) begin
      w = BASE + 32'h040 + 32'(4 * k);
      store_and_track(w, ST_W, pats[k]);
      for (int off = 0; off < 4; off++) begin
        load_and_compare(w + 32'(off), LD_BS);
        load_and_compare(w + 32'(off), LD_BU);
      end
      for (int off = 0; off < 4; off += 2) begin
        load_and_compare(w + 32'(off), LD_HS);
        load_and_compare(w + 32'(off), LD_HU);
      end
    end
  endtask

  task automatic latency_backpressure();
    logic [31:0] a;
    logic [31:0] exp;
    logic [31:0] held;
    logic        err;
    int          lat;
    a = BASE + 32'h060;
    // one-cycle latency on both paths is checked inside
    store_and_track(a, ST_W, $random(seed));
    load_and_compare(a, LD_W);
    exp = expect_load(a, LD_W);
    @(posedge clk);
    rres_ready <= 1'b0;
    do_load(a, LD_W, held, err, lat);
    check_cycles(lat, 1, "load response under back-pressure");
    check_data(LD_W, held, exp, a);
    // response parked for 5 cycles
    repeat (5) begin
      @(negedge clk);
      check_flag(rres_valid, 1'b1, "rres_valid while stalled");
      check_flag(rreq_ready, 1'b0, "rreq_ready while stalled");
      check_data(LD_W, rdata, held, a);
    end
    @(posedge clk);
    rres_ready <= 1'b1;
    @(negedge clk);
    check_flag(rres_valid, 1'b1, "rres_valid at accept");
    check_data(LD_W, rdata, exp, a);
    @(posedge clk);
    @(negedge clk);
    check_flag(rres_valid, 1'b0, "rres_valid after accept");
  endtask

  // just below the base and just past the end
  task automatic out_of_range_access();
    logic [31:0] bad [2];
    logic [31:0] got;
    logic        err;
    int          lat;
    bad = '{BASE - 32'd4, BASE + SPAN};
    foreach (bad[i]) begin
      do_store(bad[i], ST_W, 32'hdead_beef, err, lat);
      check_err(err, 1'b1, "out-of-range store");
      do_load(bad[i], LD_W, got, err, lat);
      check_err(err, 1'b1, "out-of-range load");
      check_data(LD_W, got, 32'h0000_0000, bad[i]);
    end
    // edge words of the window still intact
    load_and_compare(BASE, LD_W);
    load_and_compare(BASE + 32'h7fc, LD_W);
  endtask

  initial begin
    rstn       <= 1'b0;
    rreq_valid <= 1'b0;
    raddr      <= 32'h0000_0000;
    rfunc      <= LD_W;
    rres_ready <= 1'b1;
    wreq_valid <= 1'b0;
    waddr      <= 32'h0000_0000;
    wfunc      <= ST_W;
    wdata      <= 32'h0000_0000;
    wres_ready <= 1'b1;
    repeat (4) @(posedge clk);
    rstn <= 1'b1;
    word_round_trip();
    byte_half_merge();
    load_extension();
    latency_backpressure();
    out_of_range_access();
    $display("NO ERRORS");
    $finish;
  end

endmodule

//--- sources.f
+incdir+hw
hw/lsu_pkg.sv
hw/load_unit.sv
hw/store_unit.sv
hw/data_ram.sv
hw/lsu_top.sv
verif/lsu_tb.sv

//--- Makefile
TOP := lsu_tb
OBJ := obj_dir

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only --timing -f sources.f --top-module $(TOP)

# the log decides pass or fail
sim:
	verilator --binary --timing -j 0 -f sources.f --top-module $(TOP) -Mdir $(OBJ)
	./$(OBJ)/V$(TOP) | tee sim.log
	grep -q "^NO ERRORS$$" sim.log

clean:
	rm -rf $(OBJ) sim.log
